// File: logic/apb_mult_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_mult_regs (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire wallace_mult_pkg::apb_req_t apb_req,
  output wallace_mult_pkg::apb_rsp_t      apb_rsp,
  output logic                            op_valid,
  output wallace_mult_pkg::operand_t      op,
  input  wire                             res_valid,
  input  wire wallace_mult_pkg::row_t     product
);

  import wallace_mult_pkg::*;

  logic                  access;
  logic                  stall;
  logic                  xfer;
  logic                  wr_xfer;
  logic                  start;
  logic                  mapped;
  logic [APB_DATA_W-1:0] rd_data;
  logic                  busy;
  logic                  done;
  row_t                  product_q;

  assign access = apb_req.psel & apb_req.penable;

  // Product reads wait for the running operation
  assign stall = access & ~apb_req.pwrite & (apb_req.paddr == ADDR_PRODUCT) & busy;

  assign xfer    = access & ~stall;
  assign wr_xfer = xfer & apb_req.pwrite;

  // Start is dropped while busy
  assign start = wr_xfer & (apb_req.paddr == ADDR_CTRL) &
                 apb_req.pwdata[CTRL_START_BIT] & ~busy;

  // Address decode and read mux
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (apb_req.paddr)
      ADDR_OPERAND_A: rd_data = APB_DATA_W'(op.a);
      ADDR_OPERAND_B: rd_data = APB_DATA_W'(op.b);
      ADDR_CTRL:      rd_data = '0;
      ADDR_STATUS: begin
        rd_data[STATUS_BUSY_BIT] = busy;
        rd_data[STATUS_DONE_BIT] = done;
      end
      ADDR_PRODUCT:   rd_data = APB_DATA_W'(product_q);
      default:        mapped  = 1'b0;
    endcase
  end

  always_comb begin
    apb_rsp.prdata  = apb_req.pwrite ? '0 : rd_data;
    apb_rsp.pready  = ~stall;
    apb_rsp.pslverr = access & ~mapped;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op        <= '0;
      op_valid  <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      product_q <= '0;
    end else begin
      op_valid <= start;

      // Operands stay writable during an operation
      if (wr_xfer && apb_req.paddr == ADDR_OPERAND_A) begin
        op.a <= apb_req.pwdata[OPERAND_W-1:0];
      end
      if (wr_xfer && apb_req.paddr == ADDR_OPERAND_B) begin
        op.b <= apb_req.pwdata[OPERAND_W-1:0];
      end

      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (res_valid) begin
        busy      <= 1'b0;
        done      <= 1'b1;
        product_q <= product;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/csa_layer.sv
`timescale 1ns/1ns
`default_nettype none

module csa_layer #(
  parameter  int ROWS_IN  = 3,
  localparam int ROWS_OUT = 2 * (ROWS_IN / 3) + (ROWS_IN % 3)
) (
  input  wire wallace_mult_pkg::row_t rows_in  [ROWS_IN],
  output wallace_mult_pkg::row_t      rows_out [ROWS_OUT]
);

  import wallace_mult_pkg::*;

  localparam int GROUPS   = ROWS_IN / 3;
  localparam int LEFTOVER = ROWS_IN % 3;

  // Full adders across each group of three rows
  for (genvar g = 0; g < GROUPS; g++) begin : g_fa
    row_t x;
    row_t y;
    row_t z;
    row_t maj;

    assign x   = rows_in[3*g];
    assign y   = rows_in[3*g+1];
    assign z   = rows_in[3*g+2];
    assign maj = (x & y) | (x & z) | (y & z);

    assign rows_out[2*g]   = x ^ y ^ z;
    // Carry moves one column up
    assign rows_out[2*g+1] = maj << 1;
  end

  // Rows left over go to the next level untouched
  for (genvar r = 0; r < LEFTOVER; r++) begin : g_pass
    assign rows_out[2*GROUPS+r] = rows_in[3*GROUPS+r];
  end

endmodule

`default_nettype wire

// File: logic/partial_products.sv
`timescale 1ns/1ns
`default_nettype none

module partial_products (
  input  wire wallace_mult_pkg::operand_t op,
  output wallace_mult_pkg::row_t          rows [wallace_mult_pkg::NUM_PP_ROWS]
);

  import wallace_mult_pkg::*;

  // AND array with one row per bit of b
  for (genvar i = 0; i < NUM_PP_ROWS; i++) begin : g_row
    logic [OPERAND_W-1:0] and_bits;
    row_t                 wide_bits;

    assign and_bits  = op.a & {OPERAND_W{op.b[i]}};
    assign wide_bits = row_t'(and_bits);

    // Weight of row i starts at 2**i
    assign rows[i] = wide_bits << i;
  end

endmodule

`default_nettype wire

// File: logic/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           in_valid,
  input  wire payload_t in_data,
  output logic          out_valid,
  output payload_t      out_data
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= in_valid;
      // Hold last payload when the stage is empty
      if (in_valid) begin
        out_data <= in_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/wallace_mult_apb.sv
`timescale 1ns/1ns
`default_nettype none

module wallace_mult_apb (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire wallace_mult_pkg::apb_req_t apb_req,
  output wallace_mult_pkg::apb_rsp_t      apb_rsp
);

  import wallace_mult_pkg::*;

  // Register block to multiplier link
  logic     op_valid;
  operand_t op;
  logic     res_valid;
  row_t     product;

  apb_mult_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .op_valid  (op_valid),
    .op        (op),
    .res_valid (res_valid),
    .product   (product)
  );

  wallace_mult_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op        (op),
    .res_valid (res_valid),
    .product   (product)
  );

endmodule

`default_nettype wire

// File: logic/wallace_mult_core.sv
`timescale 1ns/1ns
`default_nettype none

module wallace_mult_core (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             op_valid,
  input  wire wallace_mult_pkg::operand_t op,
  output logic                            res_valid,
  output wallace_mult_pkg::row_t          product
);

  import wallace_mult_pkg::*;

  logic      s1_valid;
  operand_t  s1_op;
  row_t      pp_rows [NUM_PP_ROWS];
  csa_pair_t tree_cs;
  logic      s2_valid;
  csa_pair_t s2_cs;
  row_t      final_sum;

  // Stage 1 captures the operands
  stage_reg #(.payload_t(operand_t)) u_stage1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (op_valid),
    .in_data   (op),
    .out_valid (s1_valid),
    .out_data  (s1_op)
  );

  partial_products u_pp (
    .op   (s1_op),
    .rows (pp_rows)
  );

  wallace_tree u_tree (
    .rows (pp_rows),
    .cs   (tree_cs)
  );

  // Stage 2 holds the carry-save pair out of the tree
  stage_reg #(.payload_t(csa_pair_t)) u_stage2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s1_valid),
    .in_data   (tree_cs),
    .out_valid (s2_valid),
    .out_data  (s2_cs)
  );

  // Final carry-propagate add
  assign final_sum = s2_cs.sum_row + s2_cs.carry_row;

  // Stage 3 holds the product
  stage_reg #(.payload_t(row_t)) u_stage3 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s2_valid),
    .in_data   (final_sum),
    .out_valid (res_valid),
    .out_data  (product)
  );

endmodule

`default_nettype wire

// File: logic/wallace_mult_pkg.sv
`default_nettype none

package wallace_mult_pkg;

  // Datapath widths
  localparam int OPERAND_W   = 16;
  localparam int PRODUCT_W   = 32;
  localparam int NUM_PP_ROWS = 16;

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Register map
  localparam logic [APB_ADDR_W-1:0] ADDR_OPERAND_A = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_OPERAND_B = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_PRODUCT   = 8'h10;

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int CTRL_START_BIT  = 0;

  // Bit i of a row has weight 2**i
  typedef logic [PRODUCT_W-1:0] row_t;

  typedef struct packed {
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } operand_t;

  typedef struct packed {
    row_t sum_row;
    row_t carry_row;
  } csa_pair_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: logic/wallace_tree.sv
`timescale 1ns/1ns
`default_nettype none

module wallace_tree (
  input  wire wallace_mult_pkg::row_t rows [wallace_mult_pkg::NUM_PP_ROWS],
  output wallace_mult_pkg::csa_pair_t cs
);

  import wallace_mult_pkg::*;

  // Row count at each level of the reduction
  localparam int LEVELS [7] = '{NUM_PP_ROWS, 11, 8, 6, 4, 3, 2};

  row_t lvl1 [LEVELS[1]];
  row_t lvl2 [LEVELS[2]];
  row_t lvl3 [LEVELS[3]];
  row_t lvl4 [LEVELS[4]];
  row_t lvl5 [LEVELS[5]];
  row_t lvl6 [LEVELS[6]];

  csa_layer #(.ROWS_IN(LEVELS[0])) u_level1 (
    .rows_in  (rows),
    .rows_out (lvl1)
  );

  csa_layer #(.ROWS_IN(LEVELS[1])) u_level2 (
    .rows_in  (lvl1),
    .rows_out (lvl2)
  );

  csa_layer #(.ROWS_IN(LEVELS[2])) u_level3 (
    .rows_in  (lvl2),
    .rows_out (lvl3)
  );

  csa_layer #(.ROWS_IN(LEVELS[3])) u_level4 (
    .rows_in  (lvl3),
    .rows_out (lvl4)
  );

  csa_layer #(.ROWS_IN(LEVELS[4])) u_level5 (
    .rows_in  (lvl4),
    .rows_out (lvl5)
  );

  csa_layer #(.ROWS_IN(LEVELS[5])) u_level6 (
    .rows_in  (lvl5),
    .rows_out (lvl6)
  );

  // Last level is a single group, so row 0 is sum and row 1 is carry
  assign cs = '{sum_row: lvl6[0], carry_row: lvl6[1]};

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Release a little after the last reset edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_wallace_mult_apb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_wallace_mult_apb;

  import wallace_mult_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int NUM_RANDOM  = 200;
  // Up to eight APB transfers for each multiply, with room for the directed tests
  localparam int NUM_TRANSACTIONS   = (NUM_RANDOM + 20) * 8;
  localparam int CYCLES_PER_TRANSFER = 8;
  localparam int TIMEOUT_NS = (NUM_TRANSACTIONS * CYCLES_PER_TRANSFER + 10) * CLK_PERIOD;

  logic            clk;
  logic            rst_n;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  logic [31:0]     last_rdata;
  logic            last_slverr;
  int              last_waits;
  int              last_cycle;
  int              cycle = 0;
  logic [15:0]     lfsr_state;

  tb_clock_gen clk_gen0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  wallace_mult_apb dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_bits(input int n, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] model_product(input logic [15:0] a, input logic [15:0] b);
    return 32'(a) * 32'(b);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Runs from DRIVE_DELAY after an edge to DRIVE_DELAY after the completing edge
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr,
                pwdata: write ? wdata : '0};
    idle_cycle();
    apb_req.penable = 1'b1;
    last_waits = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      last_waits++;
      @(negedge clk);
    end
    last_rdata  = apb_rsp.prdata;
    last_slverr = apb_rsp.pslverr;
    idle_cycle();
    last_cycle = cycle;
    apb_req = '0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    apb_transfer(1'b1, addr, data);
    check_value("pslverr", 32'(last_slverr), 32'h0);
    check_value("pready wait cycles", 32'(last_waits), 32'h0);
  endtask

  task automatic read_reg(input logic [7:0] addr);
    apb_transfer(1'b0, addr, '0);
    check_value("pslverr", 32'(last_slverr), 32'h0);
    check_value("pready wait cycles", 32'(last_waits), 32'h0);
  endtask

  task automatic poll_until_done(input int start_cycle);
    int          elapsed;
    logic [31:0] exp_status;
    do begin
      read_reg(ADDR_STATUS);
      // A read samples the state left by the edge before it completes
      elapsed    = last_cycle - 1 - start_cycle;
      exp_status = '0;
      if (elapsed >= 4) begin
        exp_status[STATUS_DONE_BIT] = 1'b1;
      end else begin
        exp_status[STATUS_BUSY_BIT] = 1'b1;
      end
      check_value("status", last_rdata, exp_status);
    end while (!last_rdata[STATUS_DONE_BIT]);
  endtask

  task automatic run_multiply(input logic [15:0] a, input logic [15:0] b, input int gap);
    int start_cycle;
    write_reg(ADDR_OPERAND_A, 32'(a));
    write_reg(ADDR_OPERAND_B, 32'(b));
    write_reg(ADDR_CTRL, 32'(1) << CTRL_START_BIT);
    start_cycle = last_cycle;
    repeat (gap) idle_cycle();
    poll_until_done(start_cycle);
    read_reg(ADDR_PRODUCT);
    check_value("product", last_rdata, model_product(a, b));
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] a2;
    logic [15:0] corners [3];
    int          start_cycle;

    apb_req    = '0;
    lfsr_state = 16'd84;
    corners    = '{16'h0000, 16'h0001, 16'hFFFF};
    wait (rst_n === 1'b1);
    idle_cycle();

    read_reg(ADDR_STATUS);
    check_value("status", last_rdata, 32'h0);
    read_reg(ADDR_PRODUCT);
    check_value("product", last_rdata, 32'h0);
    read_reg(ADDR_OPERAND_A);
    check_value("operand_a", last_rdata, 32'h0);
    read_reg(ADDR_OPERAND_B);
    check_value("operand_b", last_rdata, 32'h0);

    // Alternate poll phase so both sides of the done edge get sampled
    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_bits(16, a);
      random_bits(16, b);
      run_multiply(a, b, i % 2);
    end

    foreach (corners[i]) begin
      foreach (corners[j]) begin
        run_multiply(corners[i], corners[j], 0);
      end
    end

    // Product read straight after start stalls through busy
    random_bits(16, a);
    random_bits(16, b);
    write_reg(ADDR_OPERAND_A, 32'(a));
    write_reg(ADDR_OPERAND_B, 32'(b));
    write_reg(ADDR_CTRL, 32'h1);
    start_cycle = last_cycle;
    apb_transfer(1'b0, ADDR_PRODUCT, '0);
    check_value("pslverr", 32'(last_slverr), 32'h0);
    check_value("product", last_rdata, model_product(a, b));
    check_value("pready wait cycles", 32'(last_waits), 32'd3);
    check_value("product read end cycle", 32'(last_cycle - start_cycle), 32'd5);

    // Second start during busy must not restart the core
    random_bits(16, a);
    random_bits(16, b);
    random_bits(16, a2);
    write_reg(ADDR_OPERAND_A, 32'(a));
    write_reg(ADDR_OPERAND_B, 32'(b));
    write_reg(ADDR_CTRL, 32'h1);
    start_cycle = last_cycle;
    write_reg(ADDR_OPERAND_A, 32'(a2));
    write_reg(ADDR_CTRL, 32'h1);
    poll_until_done(start_cycle);
    read_reg(ADDR_PRODUCT);
    check_value("product", last_rdata, model_product(a, b));
    write_reg(ADDR_CTRL, 32'h1);
    start_cycle = last_cycle;
    poll_until_done(start_cycle);
    read_reg(ADDR_PRODUCT);
    check_value("product", last_rdata, model_product(a2, b));

    apb_transfer(1'b0, 8'h14, '0);
    check_value("pslverr", 32'(last_slverr), 32'h1);
    apb_transfer(1'b1, 8'h40, 32'h1234_5678);
    check_value("pslverr", 32'(last_slverr), 32'h1);
    apb_transfer(1'b0, 8'hFC, '0);
    check_value("pslverr", 32'(last_slverr), 32'h1);
    write_reg(ADDR_PRODUCT, 32'hDEAD_BEEF);
    write_reg(ADDR_STATUS, 32'h0);
    read_reg(ADDR_PRODUCT);
    check_value("product", last_rdata, model_product(a2, b));
    read_reg(ADDR_STATUS);
    check_value("status", last_rdata, 32'(1) << STATUS_DONE_BIT);
    read_reg(ADDR_OPERAND_A);
    check_value("operand_a", last_rdata, 32'(a2));

    idle_cycle();
    if (dut0.u_regs.props0.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "concurrent assertions failed");
    end
  end

endmodule

`default_nettype wire

// File: testbench/wallace_mult_properties.sv
`timescale 1ns/1ns
`default_nettype none

module wallace_mult_properties (
  input wire                             clk,
  input wire                             rst_n,
  input wire wallace_mult_pkg::apb_rsp_t apb_rsp,
  input wire                             op_valid,
  input wire                             busy,
  input wire                             done
);

  int fail_count = 0;

  slverr_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pslverr |-> apb_rsp.pready)
  else begin
    fail_count = fail_count + 1;
    $error("pslverr high while pready is low");
  end

  busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy && done))
  else begin
    fail_count = fail_count + 1;
    $error("busy and done both high");
  end

  // Start pulse is a single cycle
  op_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    op_valid |=> !op_valid)
  else begin
    fail_count = fail_count + 1;
    $error("op_valid held longer than one cycle");
  end

endmodule

bind apb_mult_regs wallace_mult_properties props0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .apb_rsp  (apb_rsp),
  .op_valid (op_valid),
  .busy     (busy),
  .done     (done)
);

`default_nettype wire

// File: wallace_mult_apb.f
logic/wallace_mult_pkg.sv
logic/partial_products.sv
logic/csa_layer.sv
logic/wallace_tree.sv
logic/stage_reg.sv
logic/wallace_mult_core.sv
logic/apb_mult_regs.sv
logic/wallace_mult_apb.sv
testbench/tb_clock_gen.sv
testbench/wallace_mult_properties.sv
testbench/tb_wallace_mult_apb.sv
